// ==== flist.f ====
+incdir+src
src/lm80c_bus_pkg.sv
src/lm80c_av_pkg.sv
src/clock_enables.sv
src/io_decoder.sv
src/mem_arbiter.sv
src/video_timing.sv
src/audio_mixer.sv
src/lm80c_glue.sv
tests/tb_lm80c_glue.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the LM80C glue testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	-f flist.f --top-module tb_lm80c_glue -o sim_tb \
	&& ./obj_dir/sim_tb > "$LOG" 2>&1 \
	|| { echo "Build or simulation error"; cat "$LOG" 2>/dev/null; exit 1; }

cat "$LOG"
grep -q "^All checks passed$" "$LOG" && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== src/audio_mixer.sv ====
/* Audio mixer
   Sums the three PSG channels and drives a first order sigma-delta DAC */
`timescale 1ns/1ps
`include "lm80c_defines.svh"

module audio_mixer
	import lm80c_av_pkg::*;
(
	input  logic      ram_clock,
	input  logic      RESET,
	input  psg_chan_t chan_i,
	output logic      audio_o
);

	logic [9:0]               chan_sum;
	logic [`LM80C_AUDIO_W-1:0] dac_in;
	logic [`LM80C_AUDIO_W-1:0] acc;
	logic [`LM80C_AUDIO_W:0]   acc_next;

	// Three 8 bit levels fit in 10 bits
	assign chan_sum = 10'(chan_i.a) + 10'(chan_i.b) + 10'(chan_i.c);
	assign dac_in   = {chan_sum, 6'b000000};

	// Carry out of the low bits is the pulse density output
	assign acc_next = {1'b0, acc} + {1'b0, dac_in};

	always_ff @(posedge ram_clock) begin
		if (RESET) begin
			acc     <= '0;
			audio_o <= 1'b0;
		end else begin
			acc     <= acc_next[`LM80C_AUDIO_W-1:0];
			audio_o <= acc_next[`LM80C_AUDIO_W];
		end
	end

endmodule

// ==== src/clock_enables.sv ====
/* Clock enables
   Divides ram_clock into the Z80 enable and the pixel enable */
`timescale 1ns/1ps
`include "lm80c_defines.svh"

module clock_enables (
	input  logic ram_clock,
	input  logic RESET,
	output logic cpu_ce_o,
	output logic pix_ce_o
);

	localparam int CPU_W = $clog2(`LM80C_CPU_DIV);
	localparam int PIX_W = $clog2(`LM80C_PIX_DIV);
	localparam logic [CPU_W-1:0] CPU_LAST = CPU_W'(`LM80C_CPU_DIV - 1);
	localparam logic [PIX_W-1:0] PIX_LAST = PIX_W'(`LM80C_PIX_DIV - 1);

	logic [CPU_W-1:0] cpu_cnt;
	// Divide by two, so this is just a toggle flag
	logic [PIX_W-1:0] pix_cnt;

	always_ff @(posedge ram_clock) begin
		if (RESET) begin
			cpu_cnt  <= '0;
			pix_cnt  <= '0;
			cpu_ce_o <= 1'b0;
			pix_ce_o <= 1'b0;
		end else begin
			cpu_cnt  <= (cpu_cnt == CPU_LAST) ? '0 : cpu_cnt + 1'b1;
			pix_cnt  <= (pix_cnt == PIX_LAST) ? '0 : pix_cnt + 1'b1;
			// Enable rises on the wrap, first one a full period after reset
			cpu_ce_o <= (cpu_cnt == CPU_LAST);
			pix_ce_o <= (pix_cnt == PIX_LAST);
		end
	end

	// CPU enable is a single cycle pulse
	a_cpu_ce_pulse : assert property (
		@(posedge ram_clock) disable iff (RESET) cpu_ce_o |=> !cpu_ce_o
	);

endmodule

// ==== src/io_decoder.sv ====
/* I/O decoder
   Registered chip selects and strobes, LED port latch and CPU read data mux */
`timescale 1ns/1ps
`include "lm80c_defines.svh"

module io_decoder
	import lm80c_bus_pkg::*;
	import lm80c_av_pkg::*;
(
	input  logic       ram_clock,
	input  logic       RESET,
	input  cpu_bus_t   bus_i,
	input  periph_rd_t periph_i,
	input  logic [7:0] ram_q_i,
	output logic [7:0] cpu_din_o,
	output logic       ctc_ce_n_o,
	output logic       psg_bdir_o,
	output logic       psg_bc_o,
	output logic       vdp_csr_n_o,
	output logic       vdp_csw_n_o,
	output disp_mode_e disp_mode_o
);

	// Read source bits, one hot
	localparam int SRC_ZERO = 0;
	localparam int SRC_CTC  = 1;
	localparam int SRC_VDP  = 2;
	localparam int SRC_PSG  = 3;
	localparam int SRC_LED  = 4;
	localparam int SRC_RAM  = 5;

	io_dev_e    dev_sel;
	io_dev_e    dev_next;
	logic       mem_cyc;
	logic [7:0] led_latch;
	logic [5:0] rd_src;
	logic [7:0] rd_data;

	// I/O cycle only, memory cycles fall through to DEV_NONE
	always_comb begin
		dev_next = DEV_NONE;
		if (bus_i.iorq && !bus_i.mreq) begin
			if (bus_i.addr[7:0] == `LM80C_PORT_LED) begin
				dev_next = DEV_LED;
			end else begin
				case (bus_i.addr[7:4])
					`LM80C_PORT_PIO: dev_next = DEV_PIO;
					`LM80C_PORT_CTC: dev_next = DEV_CTC;
					`LM80C_PORT_SIO: dev_next = DEV_SIO;
					`LM80C_PORT_VDP: dev_next = DEV_VDP;
					`LM80C_PORT_PSG: dev_next = DEV_PSG;
					default:         dev_next = DEV_NONE;
				endcase
			end
		end
	end

	// Selects and strobes
	always_ff @(posedge ram_clock) begin
		if (RESET) begin
			dev_sel     <= DEV_NONE;
			mem_cyc     <= 1'b0;
			psg_bdir_o  <= 1'b0;
			psg_bc_o    <= 1'b0;
			vdp_csr_n_o <= 1'b1;
			vdp_csw_n_o <= 1'b1;
			led_latch   <= 8'(`LM80C_LED_RESET);
		end else begin
			dev_sel     <= dev_next;
			// Memory cycle flag, aligned with the device select
			mem_cyc     <= bus_i.mreq;
			// Strobes follow the select one cycle later
			psg_bdir_o  <= (dev_sel == DEV_PSG) && bus_i.wr;
			psg_bc_o    <= (dev_sel == DEV_PSG) && !bus_i.addr[0];
			vdp_csr_n_o <= !((dev_sel == DEV_VDP) && bus_i.rd);
			vdp_csw_n_o <= !((dev_sel == DEV_VDP) && bus_i.wr);
			if (dev_sel == DEV_LED && bus_i.wr) begin
				led_latch <= bus_i.dout;
			end
		end
	end

	assign ctc_ce_n_o  = (dev_sel != DEV_CTC);
	// Any nonzero LED value switches to the generated raster
	assign disp_mode_o = (led_latch != 8'h00) ? DISP_GENERATED : DISP_PASSTHRU;

	always_comb begin
		rd_src          = '0;
		rd_src[SRC_RAM] = mem_cyc;
		case (dev_sel)
			DEV_PIO, DEV_SIO: rd_src[SRC_ZERO] = 1'b1;
			DEV_CTC:          rd_src[SRC_CTC]  = 1'b1;
			DEV_VDP:          rd_src[SRC_VDP]  = 1'b1;
			DEV_PSG:          rd_src[SRC_PSG]  = 1'b1;
			DEV_LED:          rd_src[SRC_LED]  = 1'b1;
			default:          ;
		endcase
	end

	// AND-OR mux, PIO and SIO contribute nothing
	assign rd_data = ({8{rd_src[SRC_CTC]}} & periph_i.ctc)
		| ({8{rd_src[SRC_VDP]}} & periph_i.vdp)
		| ({8{rd_src[SRC_PSG]}} & periph_i.psg)
		| ({8{rd_src[SRC_LED]}} & led_latch)
		| ({8{rd_src[SRC_RAM]}} & ram_q_i);

	// Read data holds until the next read or interrupt acknowledge
	always_ff @(posedge ram_clock) begin
		if (bus_i.rd) begin
			cpu_din_o <= rd_data;
		end else if (bus_i.iorq && bus_i.m1) begin
			// Interrupt acknowledge, CTC puts its vector on the bus
			cpu_din_o <= periph_i.ctc;
		end
	end

	// No I/O select may overlap a memory cycle
	a_rd_src_onehot : assert property (
		@(posedge ram_clock) disable iff (RESET) $onehot0(rd_src)
	);

endmodule

// ==== src/lm80c_av_pkg.sv ====
/* LM80C audio and video types
   Pixel colour, sync bundle, PSG channel levels and display mode */
package lm80c_av_pkg;

	// 6 bits per gun, as driven to the VGA pins
	typedef struct packed {
		logic [5:0] r;
		logic [5:0] g;
		logic [5:0] b;
	} rgb_t;

	// Syncs active low
	typedef struct packed {
		rgb_t rgb;
		logic hsync_n;
		logic vsync_n;
	} video_t;

	// PSG analog levels
	typedef struct packed {
		logic [7:0] a;
		logic [7:0] b;
		logic [7:0] c;
	} psg_chan_t;

	typedef enum logic {
		DISP_PASSTHRU  = 1'b0,
		DISP_GENERATED = 1'b1
	} disp_mode_e;

endpackage

// ==== src/lm80c_bus_pkg.sv ====
/* LM80C bus types
   CPU bus bundle, decoded I/O target, peripheral read bytes and download stream */
`include "lm80c_defines.svh"

package lm80c_bus_pkg;

	// Z80 bus as seen by the glue, strobes active high
	typedef struct packed {
		logic [`LM80C_ADDR_W-1:0] addr;
		logic [`LM80C_DATA_W-1:0] dout;
		logic rd;
		logic wr;
		logic iorq;
		logic mreq;
		logic m1;
	} cpu_bus_t;

	// Registered I/O select
	typedef enum logic [2:0] {
		DEV_NONE = 3'd0,
		DEV_PIO  = 3'd1,
		DEV_CTC  = 3'd2,
		DEV_SIO  = 3'd3,
		DEV_VDP  = 3'd4,
		DEV_PSG  = 3'd5,
		DEV_LED  = 3'd6
	} io_dev_e;

	// Read bytes coming back from the external cores
	typedef struct packed {
		logic [`LM80C_DATA_W-1:0] ctc;
		logic [`LM80C_DATA_W-1:0] vdp;
		logic [`LM80C_DATA_W-1:0] psg;
	} periph_rd_t;

	// ROM download stream, wr is a single cycle pulse
	typedef struct packed {
		logic [`LM80C_ADDR_W-1:0] addr;
		logic [`LM80C_DATA_W-1:0] data;
		logic wr;
	} dl_write_t;

endpackage

// ==== src/lm80c_defines.svh ====
/* LM80C glue constants
   Bus widths, I/O port codes, RAM window, video totals and clock divisors */
`ifndef LM80C_DEFINES_SVH
`define LM80C_DEFINES_SVH

// Z80 bus widths
`define LM80C_ADDR_W 16
`define LM80C_DATA_W 8

// ram_clock cycles per enable
`define LM80C_CPU_DIV 6
`define LM80C_PIX_DIV 2

// Upper address nibble of each I/O device
`define LM80C_PORT_PIO 4'h0
`define LM80C_PORT_CTC 4'h1
`define LM80C_PORT_SIO 4'h2
`define LM80C_PORT_VDP 4'h3
`define LM80C_PORT_PSG 4'h4
// Fictional LED port, full low byte
`define LM80C_PORT_LED 8'hFF

// CPU writable RAM window, inclusive
`define LM80C_RAM_LO 16'h8000
`define LM80C_RAM_HI 16'hBFFF

// Video raster, pixels and lines
`define LM80C_H_TOTAL 342
`define LM80C_V_TOTAL 261
`define LM80C_HSYNC_LEN 20
`define LM80C_VSYNC_LEN 4
`define LM80C_HBLANK_LO 60
`define LM80C_HBLANK_HI 340
`define LM80C_VBLANK_LEN 8

`define LM80C_LED_RESET 1
`define LM80C_AUDIO_W 16

`endif

// ==== src/lm80c_glue.sv ====
/* LM80C glue top level
   Connects clock enables, I/O decode, memory arbiter, video timing and audio DAC */
`timescale 1ns/1ps

module lm80c_glue
	import lm80c_bus_pkg::*;
	import lm80c_av_pkg::*;
(
	input  logic       ram_clock,
	input  logic       RESET,
	input  cpu_bus_t   bus_i,
	input  periph_rd_t periph_i,
	input  dl_write_t  dl_i,
	input  logic       downloading_i,
	input  logic       boot_done_i,
	input  psg_chan_t  chan_i,
	input  video_t     vdp_video_i,
	output logic [7:0] cpu_din_o,
	output logic       cpu_ce_o,
	output logic       cpu_wait_o,
	output logic       ctc_ce_n_o,
	output logic       psg_bdir_o,
	output logic       psg_bc_o,
	output logic       vdp_csr_n_o,
	output logic       vdp_csw_n_o,
	output video_t     video_o,
	output logic       csync_n_o,
	output logic       audio_o
);

	logic       pix_ce;
	logic [7:0] ram_q;
	disp_mode_e disp_mode;

	clock_enables i_clock_enables (
		.ram_clock (ram_clock),
		.RESET     (RESET),
		.cpu_ce_o  (cpu_ce_o),
		.pix_ce_o  (pix_ce)
	);

	io_decoder i_io_decoder (
		.ram_clock   (ram_clock),
		.RESET       (RESET),
		.bus_i       (bus_i),
		.periph_i    (periph_i),
		.ram_q_i     (ram_q),
		.cpu_din_o   (cpu_din_o),
		.ctc_ce_n_o  (ctc_ce_n_o),
		.psg_bdir_o  (psg_bdir_o),
		.psg_bc_o    (psg_bc_o),
		.vdp_csr_n_o (vdp_csr_n_o),
		.vdp_csw_n_o (vdp_csw_n_o),
		.disp_mode_o (disp_mode)
	);

	// System RAM, shared by ROM download and CPU
	mem_arbiter i_mem_arbiter (
		.ram_clock     (ram_clock),
		.RESET         (RESET),
		.bus_i         (bus_i),
		.dl_i          (dl_i),
		.downloading_i (downloading_i),
		.boot_done_i   (boot_done_i),
		.ram_q_o       (ram_q),
		.cpu_wait_o    (cpu_wait_o)
	);

	video_timing i_video_timing (
		.ram_clock   (ram_clock),
		.RESET       (RESET),
		.pix_ce_i    (pix_ce),
		.mode_i      (disp_mode),
		.vdp_video_i (vdp_video_i),
		.video_o     (video_o),
		.csync_n_o   (csync_n_o)
	);

	audio_mixer i_audio_mixer (
		.ram_clock (ram_clock),
		.RESET     (RESET),
		.chan_i    (chan_i),
		.audio_o   (audio_o)
	);

endmodule

// ==== src/mem_arbiter.sv ====
/* Memory arbiter
   Selects download stream or CPU for the 64 KB system RAM and drives CPU wait */
`timescale 1ns/1ps
`include "lm80c_defines.svh"

module mem_arbiter
	import lm80c_bus_pkg::*;
(
	input  logic       ram_clock,
	input  logic       RESET,
	input  cpu_bus_t   bus_i,
	input  dl_write_t  dl_i,
	input  logic       downloading_i,
	input  logic       boot_done_i,
	output logic [7:0] ram_q_o,
	output logic       cpu_wait_o
);

	localparam int DEPTH = 1 << `LM80C_ADDR_W;

	logic [`LM80C_DATA_W-1:0] ram_mem [0:DEPTH-1];

	logic [`LM80C_ADDR_W-1:0] ram_addr_q;
	logic [`LM80C_DATA_W-1:0] ram_data_q;
	logic                     ram_we_q;
	logic                     in_window;

	// CPU may only write the middle 16 KB
	assign in_window = (bus_i.addr >= `LM80C_RAM_LO) && (bus_i.addr <= `LM80C_RAM_HI);

	// Address and data are payload
	always_ff @(posedge ram_clock) begin
		if (downloading_i) begin
			ram_addr_q <= dl_i.addr;
			ram_data_q <= dl_i.data;
		end else begin
			ram_addr_q <= bus_i.addr;
			ram_data_q <= bus_i.dout;
		end
	end

	always_ff @(posedge ram_clock) begin
		if (RESET) begin
			ram_we_q <= 1'b0;
		end else if (downloading_i) begin
			// Download writes anywhere
			ram_we_q <= dl_i.wr;
		end else begin
			ram_we_q <= bus_i.wr && bus_i.mreq && in_window;
		end
	end

	// Synchronous byte RAM, read data one cycle after the address register
	always_ff @(posedge ram_clock) begin
		if (ram_we_q) begin
			ram_mem[ram_addr_q] <= ram_data_q;
		end
		ram_q_o <= ram_mem[ram_addr_q];
	end

	// CPU held off while the ROM is still arriving
	assign cpu_wait_o = downloading_i || !boot_done_i;

	// CPU writes seen at the RAM port stay inside the window
	a_no_write_outside_window : assert property (
		@(posedge ram_clock) disable iff (RESET)
		(ram_we_q && !$past(downloading_i))
			|-> (ram_addr_q >= `LM80C_RAM_LO) && (ram_addr_q <= `LM80C_RAM_HI)
	);

endmodule

// ==== src/video_timing.sv ====
/* Video timing
   Raster counters, sync and blanking, choosing VDP passthrough or generated timing */
`timescale 1ns/1ps
`include "lm80c_defines.svh"

module video_timing
	import lm80c_av_pkg::*;
(
	input  logic       ram_clock,
	input  logic       RESET,
	input  logic       pix_ce_i,
	input  disp_mode_e mode_i,
	input  video_t     vdp_video_i,
	output video_t     video_o,
	output logic       csync_n_o
);

	localparam int HC_W = $clog2(`LM80C_H_TOTAL);
	localparam int VC_W = $clog2(`LM80C_V_TOTAL);

	localparam logic [HC_W-1:0] H_LAST     = HC_W'(`LM80C_H_TOTAL - 1);
	localparam logic [VC_W-1:0] V_LAST     = VC_W'(`LM80C_V_TOTAL - 1);
	localparam logic [HC_W-1:0] HSYNC_END  = HC_W'(`LM80C_HSYNC_LEN);
	localparam logic [VC_W-1:0] VSYNC_END  = VC_W'(`LM80C_VSYNC_LEN);
	localparam logic [HC_W-1:0] HBLANK_LO  = HC_W'(`LM80C_HBLANK_LO);
	localparam logic [HC_W-1:0] HBLANK_HI  = HC_W'(`LM80C_HBLANK_HI);
	localparam logic [VC_W-1:0] VBLANK_END = VC_W'(`LM80C_VBLANK_LEN);

	logic [HC_W-1:0] hcnt;
	logic [VC_W-1:0] vcnt;
	logic            blank;
	video_t          gen_video;

	// One pixel per enable
	always_ff @(posedge ram_clock) begin
		if (RESET) begin
			hcnt <= '0;
			vcnt <= '0;
		end else if (pix_ce_i) begin
			if (hcnt == H_LAST) begin
				hcnt <= '0;
				vcnt <= (vcnt == V_LAST) ? '0 : vcnt + 1'b1;
			end else begin
				hcnt <= hcnt + 1'b1;
			end
		end
	end

	// Top lines and both line edges are blanked
	assign blank = (vcnt < VBLANK_END) || (hcnt < HBLANK_LO) || (hcnt > HBLANK_HI);

	always_comb begin
		gen_video         = vdp_video_i;
		gen_video.hsync_n = (hcnt >= HSYNC_END);
		gen_video.vsync_n = (vcnt >= VSYNC_END);
		if (blank) begin
			gen_video.rgb = '0;
		end
	end

	// Output register, one cycle behind the counters
	always_ff @(posedge ram_clock) begin
		if (mode_i == DISP_GENERATED) begin
			video_o <= gen_video;
		end else begin
			video_o <= vdp_video_i;
		end
	end

	// Composite sync low while either sync is low
	assign csync_n_o = video_o.hsync_n && video_o.vsync_n;

endmodule

// ==== tests/tb_lm80c_glue.sv ====
/* LM80C glue testbench
   Plays the Z80 bus and the external cores, runs directed tests on the glue */
`timescale 1ns/1ps
`include "lm80c_defines.svh"

module tb_lm80c_glue
	import lm80c_bus_pkg::*;
	import lm80c_av_pkg::*;
();

	logic       ram_clock;
	logic       RESET;
	cpu_bus_t   bus;
	periph_rd_t periph;
	dl_write_t  dl;
	logic       downloading;
	logic       boot_done;
	psg_chan_t  chan;
	video_t     vdp_video;
	logic [7:0] cpu_din;
	logic       cpu_ce;
	logic       cpu_wait;
	logic       ctc_ce_n;
	logic       psg_bdir;
	logic       psg_bc;
	logic       vdp_csr_n;
	logic       vdp_csw_n;
	video_t     video;
	logic       csync_n;
	logic       audio;

	int          n_err;
	int          n_timeout;
	logic [31:0] lcg_state;
	logic [7:0]  exp_lo [16];
	logic [7:0]  exp_hi [16];
	// Strobe activity seen during the last bus cycle
	logic        saw_bdir;
	logic        saw_bc;
	logic        saw_csr_low;
	logic        saw_csw_low;
	logic        saw_ctc_low;

	lm80c_glue i_lm80c_glue (
		.ram_clock     (ram_clock),
		.RESET         (RESET),
		.bus_i         (bus),
		.periph_i      (periph),
		.dl_i          (dl),
		.downloading_i (downloading),
		.boot_done_i   (boot_done),
		.chan_i        (chan),
		.vdp_video_i   (vdp_video),
		.cpu_din_o     (cpu_din),
		.cpu_ce_o      (cpu_ce),
		.cpu_wait_o    (cpu_wait),
		.ctc_ce_n_o    (ctc_ce_n),
		.psg_bdir_o    (psg_bdir),
		.psg_bc_o      (psg_bc),
		.vdp_csr_n_o   (vdp_csr_n),
		.vdp_csw_n_o   (vdp_csw_n),
		.video_o       (video),
		.csync_n_o     (csync_n),
		.audio_o       (audio)
	);

	// 40 ns ram_clock
	initial begin
		ram_clock = 1'b0;
		forever #20 ram_clock = ~ram_clock;
	end

	// Inputs move and outputs are read 2 ns after the edge
	task automatic step_clock();
		@(posedge ram_clock);
		#2;
	endtask

	function automatic logic [7:0] rand_byte();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[23:16];
	endfunction

	function automatic video_t rand_video();
		video_t     v;
		logic [7:0] r0;
		logic [7:0] r1;
		logic [7:0] r2;
		r0 = rand_byte();
		r1 = rand_byte();
		r2 = rand_byte();
		// Red never zero, so blanking shows up
		v.rgb.r   = r0[5:0] | 6'h01;
		v.rgb.g   = r1[5:0];
		v.rgb.b   = r2[5:0];
		v.hsync_n = r0[6];
		v.vsync_n = r0[7];
		return v;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		n_err++;
		$display("ERR %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
	endtask

	task automatic note_timeout(input string what);
		n_timeout++;
		$display("Timeout while waiting for %s at %0t", what, $time);
	endtask

	task automatic wait_cpu_ce();
		int cnt;
		cnt = 0;
		do begin
			step_clock();
			cnt++;
		end while (!cpu_ce && cnt < 4 * `LM80C_CPU_DIV);
		if (!cpu_ce) begin
			note_timeout("cpu_ce_o");
		end
	endtask

	// One CPU enable period on the bus, read data taken at its end
	task automatic run_bus_cycle(input cpu_bus_t b, output logic [7:0] din);
		wait_cpu_ce();
		bus         = b;
		saw_bdir    = 1'b0;
		saw_bc      = 1'b0;
		saw_csr_low = 1'b0;
		saw_csw_low = 1'b0;
		saw_ctc_low = 1'b0;
		repeat (`LM80C_CPU_DIV) begin
			step_clock();
			if (psg_bdir) begin
				saw_bdir = 1'b1;
			end
			if (psg_bc) begin
				saw_bc = 1'b1;
			end
			if (!vdp_csr_n) begin
				saw_csr_low = 1'b1;
			end
			if (!vdp_csw_n) begin
				saw_csw_low = 1'b1;
			end
			if (!ctc_ce_n) begin
				saw_ctc_low = 1'b1;
			end
		end
		din = cpu_din;
		bus = '0;
	endtask

	task automatic bus_read(input logic [15:0] addr, input logic io, output logic [7:0] din);
		cpu_bus_t b;
		b      = '0;
		b.addr = addr;
		b.rd   = 1'b1;
		b.iorq = io;
		b.mreq = !io;
		run_bus_cycle(b, din);
	endtask

	task automatic bus_write(input logic [15:0] addr, input logic io, input logic [7:0] data);
		cpu_bus_t   b;
		logic [7:0] din;
		b      = '0;
		b.addr = addr;
		b.dout = data;
		b.wr   = 1'b1;
		b.iorq = io;
		b.mreq = !io;
		run_bus_cycle(b, din);
	endtask

	// Single cycle write pulse from the ROM loader
	task automatic dl_write(input logic [15:0] addr, input logic [7:0] data);
		dl.addr = addr;
		dl.data = data;
		dl.wr   = 1'b1;
		step_clock();
		dl.wr = 1'b0;
		if (cpu_wait !== 1'b1) begin
			report_mismatch("cpu_wait_o", cpu_wait, 1);
		end
		step_clock();
	endtask

	task automatic clock_enable_rhythm();
		int k;
		int highs;
		highs = 0;
		// First enable 6 cycles after reset, then every 6
		for (k = 1; k <= 60; k++) begin
			step_clock();
			if (cpu_ce !== (k % `LM80C_CPU_DIV == 0)) begin
				report_mismatch("cpu_ce_o", cpu_ce, k % `LM80C_CPU_DIV == 0);
			end
			if (cpu_ce) begin
				highs++;
			end
		end
		if (highs != 10) begin
			report_mismatch("cpu_ce_o pulse count", highs, 10);
		end
	endtask

	task automatic download_then_read();
		int         i;
		logic [7:0] din;
		boot_done   = 1'b0;
		downloading = 1'b0;
		step_clock();
		if (cpu_wait !== 1'b1) begin
			report_mismatch("cpu_wait_o", cpu_wait, 1);
		end
		downloading = 1'b1;
		for (i = 0; i < 16; i++) begin
			exp_lo[i] = rand_byte();
			exp_hi[i] = rand_byte();
			dl_write(16'(i), exp_lo[i]);
			dl_write(16'h8000 + 16'(i), exp_hi[i]);
		end
		step_clock();
		downloading = 1'b0;
		step_clock();
		// Boot not done yet, CPU still held
		if (cpu_wait !== 1'b1) begin
			report_mismatch("cpu_wait_o", cpu_wait, 1);
		end
		boot_done = 1'b1;
		step_clock();
		if (cpu_wait !== 1'b0) begin
			report_mismatch("cpu_wait_o", cpu_wait, 0);
		end
		// A download after boot holds the CPU on its own
		downloading = 1'b1;
		step_clock();
		if (cpu_wait !== 1'b1) begin
			report_mismatch("cpu_wait_o", cpu_wait, 1);
		end
		downloading = 1'b0;
		step_clock();
		if (cpu_wait !== 1'b0) begin
			report_mismatch("cpu_wait_o", cpu_wait, 0);
		end
		for (i = 0; i < 16; i++) begin
			bus_read(16'(i), 1'b0, din);
			if (din !== exp_lo[i]) begin
				report_mismatch("cpu_din_o", din, exp_lo[i]);
			end
			bus_read(16'h8000 + 16'(i), 1'b0, din);
			if (din !== exp_hi[i]) begin
				report_mismatch("cpu_din_o", din, exp_hi[i]);
			end
		end
	endtask

	task automatic ram_write_window();
		logic [7:0] data;
		logic [7:0] din;
		data = rand_byte();
		bus_write(16'h8000, 1'b0, data);
		bus_read(16'h8000, 1'b0, din);
		if (din !== data) begin
			report_mismatch("cpu_din_o", din, data);
		end
		// Top byte of the window
		data = rand_byte();
		bus_write(16'hBFFF, 1'b0, data);
		bus_read(16'hBFFF, 1'b0, din);
		if (din !== data) begin
			report_mismatch("cpu_din_o", din, data);
		end
		// ROM area, write must be dropped
		bus_write(16'h0000, 1'b0, ~exp_lo[0]);
		bus_read(16'h0000, 1'b0, din);
		if (din !== exp_lo[0]) begin
			report_mismatch("cpu_din_o", din, exp_lo[0]);
		end
	endtask

	task automatic io_decode_reads();
		cpu_bus_t   ack;
		logic [7:0] din;
		periph.ctc = rand_byte();
		periph.vdp = rand_byte();
		periph.psg = rand_byte();
		bus_read(16'h0012, 1'b1, din);
		if (din !== periph.ctc) begin
			report_mismatch("cpu_din_o", din, periph.ctc);
		end
		if (!saw_ctc_low) begin
			n_err++;
			$display("CTC read never pulled ctc_ce_n_o low at %0t", $time);
		end
		bus_read(16'h0031, 1'b1, din);
		if (din !== periph.vdp) begin
			report_mismatch("cpu_din_o", din, periph.vdp);
		end
		if (!saw_csr_low || saw_csw_low || saw_bdir || saw_ctc_low) begin
			n_err++;
			$display("VDP read did not pulse vdp_csr_n_o low alone at %0t", $time);
		end
		bus_write(16'h0030, 1'b1, rand_byte());
		if (!saw_csw_low || saw_csr_low) begin
			n_err++;
			$display("VDP write did not pulse vdp_csw_n_o low alone at %0t", $time);
		end
		// Register port, BC1 high without BDIR
		bus_read(16'h0040, 1'b1, din);
		if (din !== periph.psg) begin
			report_mismatch("cpu_din_o", din, periph.psg);
		end
		if (!saw_bc || saw_bdir) begin
			n_err++;
			$display("PSG read did not raise psg_bc_o alone at %0t", $time);
		end
		// PIO and SIO have no read path
		bus_read(16'h0001, 1'b1, din);
		if (din !== 8'h00) begin
			report_mismatch("cpu_din_o", din, 0);
		end
		bus_read(16'h0023, 1'b1, din);
		if (din !== 8'h00) begin
			report_mismatch("cpu_din_o", din, 0);
		end
		// Interrupt acknowledge, M1 with IORQ
		ack      = '0;
		ack.iorq = 1'b1;
		ack.m1   = 1'b1;
		run_bus_cycle(ack, din);
		if (din !== periph.ctc) begin
			report_mismatch("cpu_din_o", din, periph.ctc);
		end
		// Data port write, BDIR high and BC1 low
		bus_write(16'h0041, 1'b1, rand_byte());
		if (!saw_bdir || saw_bc) begin
			n_err++;
			$display("PSG write did not raise psg_bdir_o alone at %0t", $time);
		end
	endtask

	// One generated line, timed from hsync fall to hsync fall
	task automatic measure_line();
		int cnt;
		int low_len;
		int line_len;
		cnt = 0;
		while (video.hsync_n !== 1'b1 && cnt < 800) begin
			step_clock();
			cnt++;
		end
		if (cnt >= 800) begin
			note_timeout("hsync_n high");
		end
		cnt = 0;
		while (video.hsync_n !== 1'b0 && cnt < 800) begin
			step_clock();
			cnt++;
		end
		if (cnt >= 800) begin
			note_timeout("hsync_n falling edge");
		end
		low_len = 0;
		while (video.hsync_n === 1'b0 && low_len < 800) begin
			if (video.rgb !== '0) begin
				report_mismatch("video_o.rgb", video.rgb, 0);
			end
			if (csync_n !== 1'b0) begin
				report_mismatch("csync_n_o", csync_n, 0);
			end
			step_clock();
			low_len++;
		end
		line_len = low_len;
		while (video.hsync_n === 1'b1 && line_len < 1600) begin
			step_clock();
			line_len++;
		end
		if (line_len >= 1600) begin
			note_timeout("next hsync_n falling edge");
		end
		if (low_len != 2 * `LM80C_HSYNC_LEN) begin
			report_mismatch("hsync_n low cycles", low_len, 2 * `LM80C_HSYNC_LEN);
		end
		if (line_len != 2 * `LM80C_H_TOTAL) begin
			report_mismatch("line cycles", line_len, 2 * `LM80C_H_TOTAL);
		end
	endtask

	task automatic led_port_and_video();
		logic [7:0] din;
		logic [7:0] led;
		bus_read(16'h00FF, 1'b1, din);
		if (din !== 8'h01) begin
			report_mismatch("cpu_din_o", din, 1);
		end
		bus_write(16'h00FF, 1'b1, 8'h00);
		bus_read(16'h00FF, 1'b1, din);
		if (din !== 8'h00) begin
			report_mismatch("cpu_din_o", din, 0);
		end
		// LED off, VDP video passes straight through
		vdp_video = rand_video();
		step_clock();
		step_clock();
		if (video !== vdp_video) begin
			report_mismatch("video_o", video, vdp_video);
		end
		led = rand_byte() | 8'h01;
		bus_write(16'h00FF, 1'b1, led);
		bus_read(16'h00FF, 1'b1, din);
		if (din !== led) begin
			report_mismatch("cpu_din_o", din, led);
		end
		measure_line();
	endtask

	task automatic audio_pulse_density();
		int i;
		int ones;
		int expv;
		chan.a = rand_byte();
		chan.b = rand_byte();
		chan.c = rand_byte();
		// Sum of levels scaled to 16 bits
		expv = (int'(chan.a) + int'(chan.b) + int'(chan.c)) * 64;
		step_clock();
		step_clock();
		ones = 0;
		for (i = 0; i < 65536; i++) begin
			step_clock();
			if (audio) begin
				ones++;
			end
		end
		if (ones < expv - 1 || ones > expv + 1) begin
			report_mismatch("audio_o ones", ones, expv);
		end
	endtask

	initial begin
		lcg_state   = 32'h5cf2fd72;
		n_err       = 0;
		n_timeout   = 0;
		RESET       = 1'b1;
		bus         = '0;
		periph      = '0;
		dl          = '0;
		downloading = 1'b0;
		boot_done   = 1'b0;
		chan        = '0;
		vdp_video   = '0;
		saw_bdir    = 1'b0;
		saw_bc      = 1'b0;
		saw_csr_low = 1'b0;
		saw_csw_low = 1'b0;
		saw_ctc_low = 1'b0;
		repeat (8) step_clock();
		RESET = 1'b0;

		clock_enable_rhythm();
		download_then_read();
		ram_write_window();
		io_decode_reads();
		led_port_and_video();
		audio_pulse_density();

		$display("Summary: %0d value errors, %0d timeouts", n_err, n_timeout);
		if (n_err == 0 && n_timeout == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule
